// ==== src.f ====
hw/cpu_pkg.sv
hw/bus_pkg.sv
hw/cpu_alu.sv
hw/cpu_intcalc.sv
hw/cpu_regfile.sv
hw/cpu_control.sv
hw/cpu_core.sv
bench/tb_memory.sv
bench/tb_cpu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cpu
FILELIST  = src.f
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf obj_dir

// ==== bench/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu
  import cpu_pkg::*;
  import bus_pkg::*;
;

  localparam int ncase = 22;
  localparam logic [31:0] preset_word = 32'h9c3af0e5; // lives at 0x200

  logic        clk;
  logic        reset_n;
  logic        waitrequest;
  logic [31:0] address;
  logic        read;
  logic        write;
  logic [31:0] readdata;
  logic [31:0] writedata;
  logic [3:0]  byteenable;
  logic        load_en;
  logic [31:0] load_addr;
  logic [31:0] load_data;

  logic [31:0] prog [0:ncase-1][0:7];
  logic [31:0] exp_addr [0:ncase-1];
  logic [31:0] exp_data [0:ncase-1];
  logic [3:0]  exp_be [0:ncase-1];
  opcode_e     alu_ops [0:4] = '{op_add, op_sub, op_and, op_or, op_xor};

  int errors;
  int rw_clash;
  int passed;
  int failed;

  cpu_core dut0 (
    .clk(clk), .reset_n(reset_n), .waitrequest(waitrequest), .address(address),
    .read(read), .write(write), .readdata(readdata), .writedata(writedata),
    .byteenable(byteenable)
  );

  tb_memory mem0 (
    .clk(clk), .address(address), .read(read), .write(write), .writedata(writedata),
    .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
  );

  always #5 clk = ~clk;

  always @(negedge clk) begin
    if (reset_n && read && write)
      rw_clash++;
  end

  function automatic logic [31:0] encode(opcode_e op, int ra, int rb, logic [15:0] imm);
    return {op, ra[4:0], rb[4:0], imm};
  endfunction

  function automatic logic [31:0] sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic build_table();
    logic [31:0] a, b, p, f;
    logic [63:0] prod;
    int off;
    for (int c = 0; c < ncase; c++) begin
      for (int i = 0; i < 8; i++)
        prog[c][i] = encode(op_halt, 0, 0, 16'h0);
      exp_addr[c] = 32'h100;
      exp_be[c] = 4'hf;
    end
    a = sext16(16'h7a5c);
    b = sext16(16'hc3e1);
    for (int k = 0; k < 6; k++) begin
      prog[k][0] = encode(op_ldi, 1, 0, 16'h7a5c);
      prog[k][1] = encode(op_ldi, 2, 0, 16'hc3e1);
      if (k == 5)
        prog[k][2] = encode(op_addi, 3, 1, 16'hff80);
      else
        prog[k][2] = encode(alu_ops[k], 3, 1, 16'h1000); // rc = r2
      prog[k][3] = encode(op_st, 3, 0, 16'h0100);
    end
    exp_data[0] = a + b;
    exp_data[1] = a - b;
    exp_data[2] = a & b;
    exp_data[3] = a | b;
    exp_data[4] = a ^ b;
    exp_data[5] = a + sext16(16'hff80);
    // low half of one product and high half of another
    a = sext16(16'h8123);
    b = sext16(16'h6f0d);
    prog[6][0] = encode(op_ldi, 1, 0, 16'h8123);
    prog[6][1] = encode(op_ldi, 2, 0, 16'h6f0d);
    prog[6][2] = encode(op_mul, 3, 1, 16'h1000);
    prog[6][3] = encode(op_st, 3, 0, 16'h0100);
    prod = longint'($signed(a)) * longint'($signed(b));
    exp_data[6] = prod[31:0];
    p = prod[31:0];
    prog[7][0] = encode(op_ldi, 1, 0, 16'h8123);
    prog[7][1] = encode(op_ldi, 2, 0, 16'h6f0d);
    prog[7][2] = encode(op_mul, 4, 1, 16'h1000);
    prog[7][3] = encode(op_mulh, 3, 4, 16'h1000);
    prog[7][4] = encode(op_st, 3, 0, 16'h0100);
    prod = longint'($signed(p)) * longint'($signed(b));
    exp_data[7] = prod[63:32];
    // store lanes
    for (int k = 0; k < 6; k++) begin
      off = (k < 2) ? 2 * k : k - 2;
      prog[8+k][0] = encode(op_ldi, 1, 0, 16'hb7e4);
      prog[8+k][1] = encode((k < 2) ? op_sth : op_stb, 1, 0, 16'h0100 + off[15:0]);
      exp_addr[8+k] = 32'h100 + off;
      exp_be[8+k] = (k < 2) ? ((off == 0) ? 4'b0011 : 4'b1100) : (4'b0001 << off);
      exp_data[8+k] = (k < 2) ? {2{16'hb7e4}} : {4{8'he4}};
    end
    // ldb at offsets 1 and 3 then ldh at 0 and 2
    for (int k = 0; k < 4; k++) begin
      off = (k == 0) ? 1 : (k == 1) ? 3 : (k == 2) ? 0 : 2;
      f = preset_word >> (8 * off);
      prog[14+k][0] = encode((k < 2) ? op_ldb : op_ldh, 1, 0, 16'h0200 + off[15:0]);
      prog[14+k][1] = encode(op_st, 1, 0, 16'h0100);
      exp_data[14+k] = (k < 2) ? {{24{f[7]}}, f[7:0]} : {{16{f[15]}}, f[15:0]};
    end
    // beq eq, beq ne, bne eq, bne ne
    for (int k = 0; k < 4; k++) begin
      prog[18+k][0] = encode(op_ldi, 1, 0, 16'd5);
      prog[18+k][1] = encode(op_ldi, 2, 0, (k % 2 == 0) ? 16'd5 : 16'd6);
      prog[18+k][2] = encode(op_ldi, 4, 0, 16'h0111);
      prog[18+k][3] = encode(op_sub, 3, 1, 16'h1000);
      prog[18+k][4] = encode((k < 2) ? op_beq : op_bne, 0, 0, 16'd4); // skips one word
      prog[18+k][5] = encode(op_ldi, 4, 0, 16'h0222);
      prog[18+k][6] = encode(op_st, 4, 0, 16'h0100);
      exp_data[18+k] = (k == 0 || k == 3) ? 32'h111 : 32'h222;
    end
  endtask

  task automatic write_mem(input logic [31:0] a, input logic [31:0] d);
    @(posedge clk);
    load_en <= 1'b1;
    load_addr <= a;
    load_data <= d;
  endtask

  task automatic load_program(input int c);
    write_mem(32'hfffffffc, encode(op_jmp, 0, 0, 16'h0));
    write_mem(32'h0, 32'h40); // jump target
    write_mem(32'h100, 32'h0);
    write_mem(32'h200, preset_word);
    for (int i = 0; i < 8; i++)
      write_mem(32'h40 + 4 * i, prog[c][i]);
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    reset_n <= 1'b0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expv, input logic [31:0] got);
    if (got !== expv) begin
      $display("ERROR %0t: %s expected %h got %h", $time, name, expv, got);
      errors++;
    end
  endtask

  task automatic run_case(input int c);
    int errs_before;
    int clash_before;
    logic found;
    logic quiet;
    logic [31:0] got_addr, got_data;
    logic [3:0] got_be;
    errs_before = errors;
    clash_before = rw_clash;
    load_program(c);
    pulse_reset();
    found = 1'b0;
    for (int t = 0; t < 100 && !found; t++) begin
      @(negedge clk);
      if (read || write) begin
        found = 1'b1;
        if (!read) begin
          $display("first access after reset is not a read");
          errors++;
        end
        check_value("address", 32'hfffffffc, address);
      end
    end
    if (!found) begin
      $display("no access seen after reset before timeout");
      errors++;
    end
    found = 1'b0;
    for (int t = 0; t < 500 && !found; t++) begin
      @(negedge clk);
      if (write && !waitrequest && address[31:2] == 30'h40) begin
        found = 1'b1;
        got_addr = address;
        got_data = writedata;
        got_be = byteenable;
      end
    end
    if (!found) begin
      $display("no store seen before timeout");
      errors++;
    end else begin
      check_value("address", exp_addr[c], got_addr);
      check_value("writedata", exp_data[c], got_data);
      check_value("byteenable", {28'h0, exp_be[c]}, {28'h0, got_be});
      @(posedge clk);
      found = 1'b0;
      for (int t = 0; t < 100 && !found; t++) begin
        @(negedge clk);
        found = read && !waitrequest; // the halt fetch
      end
      if (!found) begin
        $display("halt fetch not seen before timeout");
        errors++;
      end else begin
        @(posedge clk);
        quiet = 1'b1;
        for (int t = 0; t < 50; t++) begin
          @(negedge clk);
          if (read || write)
            quiet = 1'b0;
        end
        if (!quiet) begin
          $display("bus access seen after halt");
          errors++;
        end
      end
    end
    if (rw_clash != clash_before) begin
      $display("read and write were high together");
      errors++;
    end
    if (errors == errs_before) begin
      $display("case %0d passed", c);
      passed++;
    end else begin
      $display("case %0d failed", c);
      failed++;
    end
  endtask

  initial begin
    clk = 1'b0;
    reset_n = 1'b0;
    load_en = 1'b0;
    load_addr = 32'h0;
    load_data = 32'h0;
    errors = 0;
    rw_clash = 0;
    passed = 0;
    failed = 0;
    build_table();
    for (int c = 0; c < ncase; c++)
      run_case(c);
    $display("%0d cases, %0d passed, %0d failed, %0d errors", ncase, passed, failed, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== bench/tb_memory.sv ====
`timescale 1ns/1ps

module tb_memory (
  input  logic        clk,
  input  logic [31:0] address,
  input  logic        read,
  input  logic        write,
  input  logic [31:0] writedata,
  input  logic [3:0]  byteenable,
  output logic [31:0] readdata,
  output logic        waitrequest,
  input  logic        load_en,
  input  logic [31:0] load_addr,
  input  logic [31:0] load_data
);

  logic [31:0] mem [0:1023]; // low 4 KB
  logic [31:0] vec_word;     // word at fffffffc
  int seed;

  initial begin
    seed = 32'hd95629f7;
    waitrequest = 1'b0;
    vec_word = 32'h0;
  end

  // unmapped space returns an address-dependent pattern
  assign readdata = !read ? 32'h0 :
                    (address == 32'hfffffffc) ? vec_word :
                    (address[31:12] == 20'h0) ? mem[address[11:2]] :
                    address ^ 32'h5a5a5a5a;

  always @(posedge clk) begin
    waitrequest <= (($random(seed) & 3) == 0); // about one edge in four stalls
    if (load_en) begin
      if (load_addr == 32'hfffffffc)
        vec_word <= load_data;
      else
        mem[load_addr[11:2]] <= load_data;
    end else if (write && !waitrequest && address[31:12] == 20'h0) begin
      for (int i = 0; i < 4; i++) begin
        if (byteenable[i])
          mem[address[11:2]][8*i +: 8] <= writedata[8*i +: 8];
      end
    end
  end

endmodule

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
  import cpu_pkg::*;
  import bus_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        waitrequest,
  output logic [31:0] address,
  output logic        read,
  output logic        write,
  input  logic [31:0] readdata,
  output logic [31:0] writedata,
  output logic [3:0]  byteenable
);

  pc_sel_e   pc_sel;
  mar_sel_e  mar_sel;
  mdr_sel_e  mdr_sel;
  reg_sel_e  reg_sel;
  alu1_sel_e alu1_sel;
  alu2_sel_e alu2_sel;
  alu_func_e alu_func;
  logic ir_write, ccr_write, reg_write, addr_sel;
  logic [reg_addr_w-1:0] reg_read_addr1, reg_read_addr2, reg_write_addr;

  logic [31:0] pc, ir, mar, mdr, aluval;
  logic [31:0] pc_next, mar_next, mdr_next;
  logic [3:0]  ccr, ccr_next;
  logic [63:0] mulval;
  logic [31:0] alu_out, alu_in1, alu_in2, reg_data1, reg_data2, reg_data_in, load_data;
  logic        alu_c, alu_n, alu_v, alu_z;
  logic [31:0] imm_sext, imm_zext;

  assign imm_sext = {{16{ir[15]}}, ir[15:0]};
  assign imm_zext = {16'h0000, ir[15:0]};
  assign address  = addr_sel ? mar : pc;

  always_comb begin
    ccr_next = ccr;
    if (ccr_write) begin
      ccr_next[ccr_c] = alu_c;
      ccr_next[ccr_n] = alu_n;
      ccr_next[ccr_v] = alu_v;
      ccr_next[ccr_z] = alu_z;
    end
  end

  // lane steering follows the enables the sequencer picked
  always_comb begin
    case (byteenable)
      be_half_lo: load_data = {{16{readdata[15]}}, readdata[15:0]};
      be_half_hi: load_data = {{16{readdata[31]}}, readdata[31:16]};
      be_byte0:   load_data = {{24{readdata[7]}}, readdata[7:0]};
      be_byte1:   load_data = {{24{readdata[15]}}, readdata[15:8]};
      be_byte2:   load_data = {{24{readdata[23]}}, readdata[23:16]};
      be_byte3:   load_data = {{24{readdata[31]}}, readdata[31:24]};
      default:    load_data = readdata;
    endcase
    case (byteenable)
      be_half_lo, be_half_hi: writedata = {2{mdr[15:0]}};
      be_byte0, be_byte1, be_byte2, be_byte3: writedata = {4{mdr[7:0]}};
      default: writedata = mdr;
    endcase
  end

  always_comb begin
    case (pc_sel)
      pc_plus4:       pc_next = pc + 32'd4;
      pc_from_mar:    pc_next = mar;
      pc_relative:    pc_next = pc + imm_sext; // pc already points past the branch
      pc_from_aluval: pc_next = aluval;
      pc_vector:      pc_next = vect_base_reset + {24'h000000, mdr[7:0]};
      default:        pc_next = pc;
    endcase
    case (mar_sel)
      mar_from_bus:    mar_next = readdata;
      mar_from_aluval: mar_next = aluval;
      default:         mar_next = mar;
    endcase
    case (mdr_sel)
      mdr_from_bus_lane: mdr_next = load_data;
      mdr_from_aluval:   mdr_next = aluval;
      mdr_from_reg1:     mdr_next = reg_data1;
      mdr_from_mul_lo:   mdr_next = mulval[31:0];
      mdr_from_mul_hi:   mdr_next = mulval[63:32];
      default:           mdr_next = mdr;
    endcase
    case (reg_sel)
      reg_from_mdr: reg_data_in = mdr;
      reg_imm_sext: reg_data_in = imm_sext;
      reg_imm_zext: reg_data_in = imm_zext;
      default:      reg_data_in = aluval;
    endcase
    alu_in1 = (alu1_sel == alu1_mar) ? mar : reg_data1;
    case (alu2_sel)
      alu2_imm_sext: alu_in2 = imm_sext;
      alu2_four:     alu_in2 = 32'd4;
      default:       alu_in2 = reg_data2;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc      <= '0;
      ir      <= '0;
      mdr     <= {24'h000000, reset_vector_off}; // reset vector offset
      ccr     <= '0;
    end else begin
      pc      <= pc_next;
      ir      <= ir_write ? readdata : ir;
      mdr     <= mdr_next;
      ccr     <= ccr_next;
    end
  end

  always_ff @(posedge clk) begin
    mar    <= mar_next;
    aluval <= alu_out;
  end

  cpu_control ctl0 (
    .clk(clk), .reset_n(reset_n), .ir(ir), .ccr(ccr), .waitrequest(waitrequest),
    .addr_lo(address[1:0]), .pc_sel(pc_sel), .mar_sel(mar_sel), .mdr_sel(mdr_sel),
    .reg_sel(reg_sel), .alu1_sel(alu1_sel), .alu2_sel(alu2_sel), .alu_func(alu_func),
    .ir_write(ir_write), .ccr_write(ccr_write), .reg_write(reg_write),
    .reg_read_addr1(reg_read_addr1), .reg_read_addr2(reg_read_addr2),
    .reg_write_addr(reg_write_addr), .addr_sel(addr_sel), .byteenable(byteenable),
    .read(read), .write(write)
  );

  cpu_alu alu0 (
    .in1(alu_in1), .in2(alu_in2), .func(alu_func), .out(alu_out),
    .c_out(alu_c), .n_out(alu_n), .v_out(alu_v), .z_out(alu_z)
  );

  cpu_intcalc mul0 (.clk(clk), .in1(reg_data1), .in2(reg_data2), .out(mulval));

  cpu_regfile rf0 (
    .clk(clk), .reset_n(reset_n), .read1(reg_read_addr1), .read2(reg_read_addr2),
    .write_addr(reg_write_addr), .write_data(reg_data_in), .write_en(reg_write),
    .data1(reg_data1), .data2(reg_data2)
  );

  a_rw_excl: assert property (@(posedge clk) disable iff (!reset_n) !(read && write));

  // a stalled access keeps its address, enables and strobe
  a_bus_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (read || write) && waitrequest |=>
      $stable(address) && $stable(byteenable) && $stable(read) && $stable(write));

endmodule

// ==== hw/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control
  import cpu_pkg::*;
  import bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic [31:0]           ir,
  input  logic [3:0]            ccr,
  input  logic                  waitrequest,
  input  logic [1:0]            addr_lo,
  output pc_sel_e               pc_sel,
  output mar_sel_e              mar_sel,
  output mdr_sel_e              mdr_sel,
  output reg_sel_e              reg_sel,
  output alu1_sel_e             alu1_sel,
  output alu2_sel_e             alu2_sel,
  output alu_func_e             alu_func,
  output logic                  ir_write,
  output logic                  ccr_write,
  output logic                  reg_write,
  output logic [reg_addr_w-1:0] reg_read_addr1,
  output logic [reg_addr_w-1:0] reg_read_addr2,
  output logic [reg_addr_w-1:0] reg_write_addr,
  output logic                  addr_sel,
  output logic [3:0]            byteenable,
  output logic                  read,
  output logic                  write
);

  state_e  state, state_next;
  opcode_e op;
  size_e   size;
  logic is_alu, is_load, is_store, is_mul, taken;

  assign op       = opcode_e'(ir[31:26]);
  assign is_alu   = op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi};
  assign is_load  = op inside {op_ld, op_ldh, op_ldb};
  assign is_store = op inside {op_st, op_sth, op_stb};
  assign is_mul   = op inside {op_mul, op_mulh};
  assign taken    = (op == op_bra) || (op == op_beq && ccr[ccr_z]) ||
                    (op == op_bne && !ccr[ccr_z]);
  assign size     = (op inside {op_ldh, op_sth}) ? size_half :
                    (op inside {op_ldb, op_stb}) ? size_byte : size_word;

  // store source is ra once the address is computed
  assign reg_read_addr1 = (is_store && state == st_mem_addr) ? ir[25:21] : ir[20:16];
  assign reg_read_addr2 = ir[15:11];
  assign reg_write_addr = ir[25:21];

  assign read     = state inside {st_vec_fetch, st_jmp_fetch, st_fetch} ||
                    (state == st_mem && is_load);
  assign write    = state == st_mem && is_store;
  assign addr_sel = state == st_mem;

  always_comb begin
    byteenable = be_word;
    if (state == st_mem && size == size_half)
      byteenable = addr_lo[1] ? be_half_hi : be_half_lo;
    else if (state == st_mem && size == size_byte) begin
      case (addr_lo)
        2'd0:    byteenable = be_byte0;
        2'd1:    byteenable = be_byte1;
        2'd2:    byteenable = be_byte2;
        default: byteenable = be_byte3;
      endcase
    end
  end

  always_comb begin
    state_next = state;
    pc_sel = pc_hold;
    mar_sel = mar_hold;
    mdr_sel = mdr_hold;
    reg_sel = reg_from_aluval;
    alu1_sel = alu1_reg1;
    alu2_sel = (is_alu && op != op_addi) ? alu2_reg2 : alu2_imm_sext;
    alu_func = alu_add;
    ir_write = 1'b0;
    ccr_write = 1'b0;
    reg_write = 1'b0;
    case (op)
      op_sub:  alu_func = alu_sub;
      op_and:  alu_func = alu_and;
      op_or:   alu_func = alu_or;
      op_xor:  alu_func = alu_xor;
      default: alu_func = alu_add;
    endcase
    case (state)
      st_reset_vec: begin
        pc_sel = pc_vector;
        state_next = st_vec_fetch;
      end
      st_vec_fetch, st_fetch: if (!waitrequest) begin
        ir_write = 1'b1;
        pc_sel = pc_plus4;
        state_next = (state == st_fetch) ? st_decode : st_jmp_fetch;
      end
      st_decode: begin
        case (op)
          op_jmp: state_next = st_jmp_fetch;
          op_ldi, op_ldiu, op_add, op_sub, op_and, op_or, op_xor, op_addi,
          op_mul, op_mulh, op_ld, op_ldh, op_ldb, op_st, op_sth, op_stb,
          op_bra, op_beq, op_bne: state_next = st_exec;
          default: state_next = st_halt; // op_halt and undefined opcodes
        endcase
      end
      st_exec: begin
        ccr_write = is_alu;
        if (op inside {op_bra, op_beq, op_bne} && taken)
          pc_sel = pc_relative;
        if (is_mul)
          state_next = st_mul_wait;
        else if (is_load || is_store)
          state_next = st_mem_addr;
        else
          state_next = st_writeback;
      end
      st_mul_wait: begin
        mdr_sel = (op == op_mulh) ? mdr_from_mul_hi : mdr_from_mul_lo;
        state_next = st_writeback;
      end
      st_mem_addr: begin
        mar_sel = mar_from_aluval;
        if (is_store)
          mdr_sel = mdr_from_reg1;
        state_next = st_mem;
      end
      st_mem: if (!waitrequest) begin
        if (is_load)
          mdr_sel = mdr_from_bus_lane;
        state_next = st_writeback;
      end
      st_jmp_fetch: if (!waitrequest) begin
        mar_sel = mar_from_bus;
        state_next = st_writeback;
      end
      st_writeback: begin
        reg_write = is_alu || is_load || is_mul || op inside {op_ldi, op_ldiu};
        if (is_load || is_mul)
          reg_sel = reg_from_mdr;
        else if (op == op_ldi)
          reg_sel = reg_imm_sext;
        else if (op == op_ldiu)
          reg_sel = reg_imm_zext;
        if (op == op_jmp)
          pc_sel = pc_from_mar;
        state_next = st_fetch;
      end
      default: state_next = st_halt;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      state <= st_reset_vec;
    else
      state <= state_next;
  end

  a_state_legal: assert property (@(posedge clk) disable iff (!reset_n)
    state inside {[st_reset_vec:st_halt]});

endmodule

// ==== hw/cpu_regfile.sv ====
`timescale 1ns/1ps

module cpu_regfile
  import cpu_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic [reg_addr_w-1:0] read1,
  input  logic [reg_addr_w-1:0] read2,
  input  logic [reg_addr_w-1:0] write_addr,
  input  logic [31:0]           write_data,
  input  logic                  write_en,
  output logic [31:0]           data1,
  output logic [31:0]           data2
);

  logic [31:0] regs [0:(1<<reg_addr_w)-1];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < (1 << reg_addr_w); i++)
        regs[i] <= '0;
    end else if (write_en && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

  assign data1 = (read1 == '0) ? '0 : regs[read1]; // r0 is constant zero
  assign data2 = (read2 == '0) ? '0 : regs[read2];

endmodule

// ==== hw/cpu_intcalc.sv ====
`timescale 1ns/1ps

module cpu_intcalc
  import cpu_pkg::*;
(
  input  logic                  clk,
  input  logic [data_w-1:0]     in1,
  input  logic [data_w-1:0]     in2,
  output logic [2*data_w-1:0]   out
);

  // sign-extended operands give the signed product in one register stage
  always_ff @(posedge clk) begin
    out <= {{data_w{in1[data_w-1]}}, in1} * {{data_w{in2[data_w-1]}}, in2};
  end

endmodule

// ==== hw/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu
  import cpu_pkg::*;
(
  input  logic [data_w-1:0] in1,
  input  logic [data_w-1:0] in2,
  input  alu_func_e         func,
  output logic [data_w-1:0] out,
  output logic              c_out,
  output logic              n_out,
  output logic              v_out,
  output logic              z_out
);

  logic [data_w:0] sum;

  always_comb begin
    sum = '0;
    v_out = 1'b0;
    case (func)
      alu_add: begin
        sum = {1'b0, in1} + {1'b0, in2};
        v_out = (in1[data_w-1] == in2[data_w-1]) && (sum[data_w-1] != in1[data_w-1]);
      end
      alu_sub: begin
        sum = {1'b0, in1} - {1'b0, in2}; // top bit is the borrow
        v_out = (in1[data_w-1] != in2[data_w-1]) && (sum[data_w-1] != in1[data_w-1]);
      end
      alu_and: sum[data_w-1:0] = in1 & in2;
      alu_or:  sum[data_w-1:0] = in1 | in2;
      alu_xor: sum[data_w-1:0] = in1 ^ in2;
      default: sum = '0;
    endcase
    out   = sum[data_w-1:0];
    c_out = sum[data_w];
    n_out = out[data_w-1];
    z_out = (out == '0);
  end

endmodule

// ==== hw/bus_pkg.sv ====
package bus_pkg;

  typedef enum logic [1:0] {size_word, size_half, size_byte} size_e;

  // byte enables with lane 0 on bits 7:0
  localparam logic [3:0] be_word    = 4'b1111;
  localparam logic [3:0] be_half_lo = 4'b0011;
  localparam logic [3:0] be_half_hi = 4'b1100;
  localparam logic [3:0] be_byte0   = 4'b0001;
  localparam logic [3:0] be_byte1   = 4'b0010;
  localparam logic [3:0] be_byte2   = 4'b0100;
  localparam logic [3:0] be_byte3   = 4'b1000;

  localparam logic [31:0] vect_base_reset = 32'hffffffc0;
  localparam logic [7:0] reset_vector_off = 8'h3c; // first fetch at fffffffc

endpackage

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

  localparam int reg_addr_w = 5;
  localparam int data_w = 32;

  // ccr bit positions in {c, n, v, z} order
  localparam int ccr_c = 3;
  localparam int ccr_n = 2;
  localparam int ccr_v = 1;
  localparam int ccr_z = 0;

  typedef enum logic [5:0] {
    op_ldi, op_ldiu,
    op_add, op_sub, op_and, op_or, op_xor, op_addi,
    op_mul, op_mulh,
    op_ld, op_ldh, op_ldb, op_st, op_sth, op_stb,
    op_bra, op_beq, op_bne, op_jmp,
    op_halt
  } opcode_e;

  typedef enum logic [3:0] {
    st_reset_vec, st_vec_fetch, st_fetch, st_decode, st_exec, st_mul_wait,
    st_mem_addr, st_mem, st_writeback, st_jmp_fetch, st_halt
  } state_e;

  typedef enum logic [2:0] {
    pc_hold, pc_plus4, pc_from_mar, pc_relative, pc_from_aluval, pc_vector
  } pc_sel_e;

  typedef enum logic [1:0] {mar_hold, mar_from_bus, mar_from_aluval} mar_sel_e;

  typedef enum logic [2:0] {
    mdr_hold, mdr_from_bus_lane, mdr_from_aluval, mdr_from_reg1, mdr_from_mul_lo, mdr_from_mul_hi
  } mdr_sel_e;

  typedef enum logic [2:0] {reg_from_aluval, reg_from_mdr, reg_imm_sext, reg_imm_zext} reg_sel_e;

  typedef enum logic {alu1_reg1, alu1_mar} alu1_sel_e;

  typedef enum logic [1:0] {alu2_reg2, alu2_imm_sext, alu2_four} alu2_sel_e;

  typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_func_e;

endpackage
